//--- dac_tpl_consts.svh
// Shared constants for the DAC transport channel
//   sample and word widths, lanes per clock
//   configuration address width
//   PN7 and PN15 seed lengths
`ifndef DAC_TPL_CONSTS_SVH
`define DAC_TPL_CONSTS_SVH

// Datapath geometry
`define DAC_SAMPLE_W 16
`define DAC_LANES 2
`define DAC_WORD_W 32

// Host register port
`define DAC_CFG_ADDR_W 4

// Count of leading ones loaded into each PN state on sync
`define DAC_PN15_SEED_ONES 15
`define DAC_PN7_SEED_ONES 7

`endif

//--- dac_tpl_pkg.sv
// Types for the DAC transport channel
//   data_sel_t   output source select
//   cfg_op_t     register opcodes used as write addresses
//   cfg_state_t  host handshake FSM states
`default_nettype none

`include "dac_tpl_consts.svh"

package dac_tpl_pkg;

  // Output source, unknown codes fall back to tone
  typedef enum logic [3:0] {
    SEL_TONE     = 4'd0,
    SEL_PATTERN  = 4'd1,
    SEL_DMA      = 4'd2,
    SEL_ZERO     = 4'd3,
    SEL_PN7_INV  = 4'd4,
    SEL_PN15_INV = 4'd5,
    SEL_PN7      = 4'd6,
    SEL_PN15     = 4'd7
  } data_sel_t;

  // Register map, one opcode per address
  typedef enum logic [`DAC_CFG_ADDR_W-1:0] {
    OP_SEL     = 4'd0,
    OP_FORMAT  = 4'd1,
    OP_SCALE_0 = 4'd2,
    OP_INIT_0  = 4'd3,
    OP_INCR_0  = 4'd4,
    OP_SCALE_1 = 4'd5,
    OP_INIT_1  = 4'd6,
    OP_INCR_1  = 4'd7,
    OP_PAT_0   = 4'd8,
    OP_PAT_1   = 4'd9,
    OP_SYNC    = 4'd10
  } cfg_op_t;

  // Four-phase write handshake
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WAIT_REL
  } cfg_state_t;

endpackage

`default_nettype wire

//--- dac_cfg_ctrl.sv
// Host configuration controller
//   four-phase req/ack write FSM
//   channel configuration registers
//   single-cycle sync pulse on OP_SYNC
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_cfg_ctrl (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         cfg_req,
  input  wire [`DAC_CFG_ADDR_W-1:0]   cfg_addr,
  input  wire [`DAC_SAMPLE_W-1:0]     cfg_wdata,
  output logic                        cfg_ack,
  output dac_tpl_pkg::data_sel_t      data_sel,
  output logic                        dds_format,
  output logic [`DAC_SAMPLE_W-1:0]    scale_0,
  output logic [`DAC_SAMPLE_W-1:0]    init_0,
  output logic [`DAC_SAMPLE_W-1:0]    incr_0,
  output logic [`DAC_SAMPLE_W-1:0]    scale_1,
  output logic [`DAC_SAMPLE_W-1:0]    init_1,
  output logic [`DAC_SAMPLE_W-1:0]    incr_1,
  output logic [`DAC_SAMPLE_W-1:0]    pat_0,
  output logic [`DAC_SAMPLE_W-1:0]    pat_1,
  output logic                        data_sync
);

  import dac_tpl_pkg::*;

  cfg_state_t state;
  cfg_op_t    op;

  // Address decodes straight to an opcode
  assign op = cfg_op_t'(cfg_addr);

  // ******************************
  // Handshake FSM
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cfg_ack   <= 1'b0;
      data_sync <= 1'b0;
    end else begin
      // Sync is high only for the ST_WRITE cycle
      data_sync <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cfg_req) begin
            state     <= ST_WRITE;
            data_sync <= (op == OP_SYNC);
          end
        end
        ST_WRITE: begin
          // Register loads on this edge, ack follows
          state   <= ST_WAIT_REL;
          cfg_ack <= 1'b1;
        end
        ST_WAIT_REL: begin
          // Hold ack until the host lets go of req
          if (!cfg_req) begin
            state   <= ST_IDLE;
            cfg_ack <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ******************************
  // Configuration registers
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_sel   <= SEL_ZERO;
      dds_format <= 1'b0;
      scale_0    <= '0;
      init_0     <= '0;
      incr_0     <= '0;
      scale_1    <= '0;
      init_1     <= '0;
      incr_1     <= '0;
      pat_0      <= '0;
      pat_1      <= '0;
    end else if (state == ST_WRITE) begin
      case (op)
        OP_SEL:     data_sel   <= data_sel_t'(cfg_wdata[3:0]);
        OP_FORMAT:  dds_format <= cfg_wdata[0];
        OP_SCALE_0: scale_0    <= cfg_wdata;
        OP_INIT_0:  init_0     <= cfg_wdata;
        OP_INCR_0:  incr_0     <= cfg_wdata;
        OP_SCALE_1: scale_1    <= cfg_wdata;
        OP_INIT_1:  init_1     <= cfg_wdata;
        OP_INCR_1:  incr_1     <= cfg_wdata;
        OP_PAT_0:   pat_0      <= cfg_wdata;
        OP_PAT_1:   pat_1      <= cfg_wdata;
        // OP_SYNC and unmapped addresses store nothing
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- dac_pn_gen.sv
// PN sequence word generators
//   PN15 x^15+x^14+1 and PN7 x^7+x^6+1
//   sync reload of the seed words, lane swizzle on output
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_pn_gen (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       data_sync,
  output logic [`DAC_WORD_W-1:0]    pn7_word,
  output logic [`DAC_WORD_W-1:0]    pn15_word
);

  // Next word, MSB is the oldest bit, history runs on from cur
  function automatic logic [`DAC_WORD_W-1:0] pn_next(
    input logic [`DAC_WORD_W-1:0] cur,
    input int unsigned            ord
  );
    logic [2*`DAC_WORD_W-1:0] hist;
    hist = {cur, {`DAC_WORD_W{1'b0}}};
    for (int i = `DAC_WORD_W - 1; i >= 0; i--) begin
      hist[i] = hist[i+ord] ^ hist[i+ord-1];
    end
    return hist[`DAC_WORD_W-1:0];
  endfunction

  // Seed word, ord leading ones then the sequence continued
  function automatic logic [`DAC_WORD_W-1:0] pn_seed(input int unsigned ord);
    logic [`DAC_WORD_W-1:0] s;
    s = '1;
    for (int i = `DAC_WORD_W - 1 - ord; i >= 0; i--) begin
      s[i] = s[i+ord] ^ s[i+ord-1];
    end
    return s;
  endfunction

  localparam logic [`DAC_WORD_W-1:0] PN15_SEED = pn_seed(`DAC_PN15_SEED_ONES);
  localparam logic [`DAC_WORD_W-1:0] PN7_SEED  = pn_seed(`DAC_PN7_SEED_ONES);

  logic [`DAC_WORD_W-1:0] pn15_state;
  logic [`DAC_WORD_W-1:0] pn7_state;

  // Reset and sync both restart from the seeds
  always_ff @(posedge clk) begin
    if (!rst_n || data_sync) begin
      pn15_state <= PN15_SEED;
      pn7_state  <= PN7_SEED;
    end else begin
      pn15_state <= pn_next(pn15_state, `DAC_PN15_SEED_ONES);
      pn7_state  <= pn_next(pn7_state, `DAC_PN7_SEED_ONES);
    end
  end

  // Swap samples so the oldest bits land in lane 0
  for (genvar l = 0; l < `DAC_LANES; l++) begin : g_swizzle
    assign pn15_word[(`DAC_LANES-1-l)*`DAC_SAMPLE_W +: `DAC_SAMPLE_W] =
      pn15_state[l*`DAC_SAMPLE_W +: `DAC_SAMPLE_W];
    assign pn7_word[(`DAC_LANES-1-l)*`DAC_SAMPLE_W +: `DAC_SAMPLE_W] =
      pn7_state[l*`DAC_SAMPLE_W +: `DAC_SAMPLE_W];
  end

endmodule

`default_nettype wire

//--- dac_tone_gen.sv
// Two-tone triangle synthesizer
//   per-tone phase accumulators with sync reload
//   triangle level, unsigned scale, per-lane sum
//   offset binary or two's complement output
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_tone_gen (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       data_sync,
  input  wire                       dds_format,
  input  wire [`DAC_SAMPLE_W-1:0]   scale_0,
  input  wire [`DAC_SAMPLE_W-1:0]   init_0,
  input  wire [`DAC_SAMPLE_W-1:0]   incr_0,
  input  wire [`DAC_SAMPLE_W-1:0]   scale_1,
  input  wire [`DAC_SAMPLE_W-1:0]   init_1,
  input  wire [`DAC_SAMPLE_W-1:0]   incr_1,
  output logic [`DAC_WORD_W-1:0]    tone_word
);

  // Triangle of one phase, times scale, shifted down by 16
  function automatic logic [15:0] tone_level(
    input logic [15:0] phase,
    input logic [15:0] scale
  );
    logic [14:0]        ramp;
    logic signed [16:0] level;
    logic signed [33:0] prod;
    // Falling half mirrors the rising half
    ramp  = phase[15] ? ~phase[14:0] : phase[14:0];
    level = $signed({2'b00, ramp}) - 17'sd16384;
    prod  = level * $signed({1'b0, scale});
    return prod[31:16];
  endfunction

  logic [`DAC_SAMPLE_W-1:0] phase_0;
  logic [`DAC_SAMPLE_W-1:0] phase_1;

  // Phase steps one increment per lane each clock
  always_ff @(posedge clk) begin
    if (!rst_n || data_sync) begin
      phase_0 <= init_0;
      phase_1 <= init_1;
    end else begin
      phase_0 <= phase_0 + incr_0 * 16'(`DAC_LANES);
      phase_1 <= phase_1 + incr_1 * 16'(`DAC_LANES);
    end
  end

  // ******************************
  // Per-lane sample
  // ******************************

  for (genvar l = 0; l < `DAC_LANES; l++) begin : g_lane
    logic [`DAC_SAMPLE_W-1:0] ph_0;
    logic [`DAC_SAMPLE_W-1:0] ph_1;
    logic [`DAC_SAMPLE_W-1:0] sum;

    // Lane l sits l increments ahead
    assign ph_0 = phase_0 + incr_0 * 16'(l);
    assign ph_1 = phase_1 + incr_1 * 16'(l);
    // Wraps on overflow
    assign sum  = tone_level(ph_0, scale_0) + tone_level(ph_1, scale_1);
    // Format 0 flips the MSB to offset binary
    assign tone_word[l*`DAC_SAMPLE_W +: `DAC_SAMPLE_W] =
      {sum[`DAC_SAMPLE_W-1] ^ ~dds_format, sum[`DAC_SAMPLE_W-2:0]};
  end

endmodule

`default_nettype wire

//--- dac_tpl_channel.sv
// Transmit channel datapath
//   PN and tone generator instances
//   registered source multiplexer and enable
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_tpl_channel (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [`DAC_WORD_W-1:0]          dma_data,
  input  wire dac_tpl_pkg::data_sel_t    data_sel,
  input  wire                            data_sync,
  input  wire                            dds_format,
  input  wire [`DAC_SAMPLE_W-1:0]        scale_0,
  input  wire [`DAC_SAMPLE_W-1:0]        init_0,
  input  wire [`DAC_SAMPLE_W-1:0]        incr_0,
  input  wire [`DAC_SAMPLE_W-1:0]        scale_1,
  input  wire [`DAC_SAMPLE_W-1:0]        init_1,
  input  wire [`DAC_SAMPLE_W-1:0]        incr_1,
  input  wire [`DAC_SAMPLE_W-1:0]        pat_0,
  input  wire [`DAC_SAMPLE_W-1:0]        pat_1,
  output logic [`DAC_WORD_W-1:0]         dac_data,
  output logic                           dac_enable
);

  import dac_tpl_pkg::*;

  logic [`DAC_WORD_W-1:0] pn7_word;
  logic [`DAC_WORD_W-1:0] pn15_word;
  logic [`DAC_WORD_W-1:0] tone_word;

  dac_pn_gen pn_gen_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_sync (data_sync),
    .pn7_word  (pn7_word),
    .pn15_word (pn15_word)
  );

  dac_tone_gen tone_gen_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_sync  (data_sync),
    .dds_format (dds_format),
    .scale_0    (scale_0),
    .init_0     (init_0),
    .incr_0     (incr_0),
    .scale_1    (scale_1),
    .init_1     (init_1),
    .incr_1     (incr_1),
    .tone_word  (tone_word)
  );

  // Source select, one register stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dac_data   <= '0;
      dac_enable <= 1'b0;
    end else begin
      // Only DMA data counts as live output
      dac_enable <= (data_sel == SEL_DMA);
      case (data_sel)
        SEL_PN15:     dac_data <= pn15_word;
        SEL_PN7:      dac_data <= pn7_word;
        SEL_PN15_INV: dac_data <= ~pn15_word;
        SEL_PN7_INV:  dac_data <= ~pn7_word;
        SEL_ZERO:     dac_data <= '0;
        SEL_DMA:      dac_data <= dma_data;
        // pat_1 high, pat_0 low, repeated over the word
        SEL_PATTERN:  dac_data <= {(`DAC_LANES / 2){pat_1, pat_0}};
        default:      dac_data <= tone_word;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- dac_tpl_top.sv
// DAC transport channel top level
//   host configuration controller
//   transmit channel datapath
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_tpl_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          cfg_req,
  input  wire [`DAC_CFG_ADDR_W-1:0]    cfg_addr,
  input  wire [`DAC_SAMPLE_W-1:0]      cfg_wdata,
  input  wire [`DAC_WORD_W-1:0]        dma_data,
  output wire                          cfg_ack,
  output wire [`DAC_WORD_W-1:0]        dac_data,
  output wire                          dac_enable
);

  import dac_tpl_pkg::*;

  // Configuration to channel
  data_sel_t                data_sel;
  wire                      dds_format;
  wire                      data_sync;
  wire [`DAC_SAMPLE_W-1:0]  scale_0;
  wire [`DAC_SAMPLE_W-1:0]  init_0;
  wire [`DAC_SAMPLE_W-1:0]  incr_0;
  wire [`DAC_SAMPLE_W-1:0]  scale_1;
  wire [`DAC_SAMPLE_W-1:0]  init_1;
  wire [`DAC_SAMPLE_W-1:0]  incr_1;
  wire [`DAC_SAMPLE_W-1:0]  pat_0;
  wire [`DAC_SAMPLE_W-1:0]  pat_1;

  dac_cfg_ctrl cfg_ctrl_inst (
    .clk (clk), .rst_n (rst_n),
    .cfg_req (cfg_req), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_ack (cfg_ack),
    .data_sel (data_sel), .dds_format (dds_format),
    .scale_0 (scale_0), .init_0 (init_0), .incr_0 (incr_0),
    .scale_1 (scale_1), .init_1 (init_1), .incr_1 (incr_1),
    .pat_0 (pat_0), .pat_1 (pat_1), .data_sync (data_sync)
  );

  dac_tpl_channel channel_inst (
    .clk (clk), .rst_n (rst_n), .dma_data (dma_data),
    .data_sel (data_sel), .data_sync (data_sync), .dds_format (dds_format),
    .scale_0 (scale_0), .init_0 (init_0), .incr_0 (incr_0),
    .scale_1 (scale_1), .init_1 (init_1), .incr_1 (incr_1),
    .pat_0 (pat_0), .pat_1 (pat_1),
    .dac_data (dac_data), .dac_enable (dac_enable)
  );

endmodule

`default_nettype wire

//--- dac_tpl_tb.sv
// Testbench for the DAC transport channel
//   clock, reset and cycle watchdog
//   four-phase host write and DMA drive tasks
//   PN, pattern and triangle-tone reference models
//   step runner fed from dac_tpl_patterns.txt
`default_nettype none

`include "dac_tpl_consts.svh"

module dac_tpl_tb;

  import dac_tpl_pkg::*;

  localparam int STEP_MAX = 64;

  logic                         clk;
  logic                         rst_n;
  logic                         cfg_req;
  logic [`DAC_CFG_ADDR_W-1:0]   cfg_addr;
  logic [`DAC_SAMPLE_W-1:0]     cfg_wdata;
  logic [`DAC_WORD_W-1:0]       dma_data;
  wire                          cfg_ack;
  wire  [`DAC_WORD_W-1:0]       dac_data;
  wire                          dac_enable;

  // Four hex columns per step
  logic [31:0] step_mem [0:4*STEP_MAX-1];

  // Channel configuration as last written by the host
  data_sel_t                sel_shadow;
  logic                     fmt_shadow;
  logic [`DAC_SAMPLE_W-1:0] scale_s [0:1];
  logic [`DAC_SAMPLE_W-1:0] init_s [0:1];
  logic [`DAC_SAMPLE_W-1:0] incr_s [0:1];
  logic [`DAC_SAMPLE_W-1:0] pat_s [0:1];

  int cyc = 0;
  int limit = 1000;
  int sync_edge = 0;
  int seed = 43;

  dac_tpl_top dac_tpl_top_inst (
    .clk (clk), .rst_n (rst_n),
    .cfg_req (cfg_req), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata),
    .dma_data (dma_data), .cfg_ack (cfg_ack),
    .dac_data (dac_data), .dac_enable (dac_enable)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at first failure");
  endtask

  // Edge counter doubles as the hang watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("run hung waiting for the DUT after %0d cycles", cyc);
      abort_run();
    end
  end

  // ******************************
  // Compare tasks
  // ******************************

  task automatic check_word(input logic [31:0] exp, input logic [31:0] act, input string what);
    if (act !== exp) begin
      $display("error at time %0t: %s expected %h actual %h", $time, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sel(input data_sel_t exp, input data_sel_t act, input string what);
    if (act !== exp) begin
      $display("error at time %0t: %s expected %0d actual %0d", $time, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      $display("error at time %0t: %s expected %b actual %b", $time, what, exp, act);
      abort_run();
    end
  endtask

  // ******************************
  // Reference models
  // ******************************

  // PN word k after sync built bit by bit from ord leading ones
  function automatic logic [31:0] pn_ref(input int ord, input int k);
    logic [15:0] h;
    logic [15:0] tap;
    logic [31:0] w;
    logic        b;
    h = '0;
    w = '0;
    for (int t = 0; t < 32 * k + 32; t++) begin
      tap = h >> (ord - 2);
      b = (t < ord) ? 1'b1 : (tap[1] ^ tap[0]);
      h = {h[14:0], b};
      w = {w[30:0], b};
    end
    // Oldest half goes to the low sample
    return {w[15:0], w[31:16]};
  endfunction

  // One lane of the two-tone sum for word k after sync
  function automatic logic [15:0] tone_lane(input int k, input int lane);
    logic [15:0] ph;
    int          ramp;
    int          total;
    total = 0;
    for (int t = 0; t < 2; t++) begin
      ph    = 16'(init_s[t] + incr_s[t] * (2 * k + lane));
      ramp  = ph[15] ? 32767 - int'(ph[14:0]) : int'(ph[14:0]);
      total += ((ramp - 16384) * int'(scale_s[t])) >>> 16;
    end
    // Offset binary flips the sign bit
    return 16'(total) ^ (fmt_shadow ? 16'h0000 : 16'h8000);
  endfunction

  function automatic logic [31:0] expected_word(input data_sel_t sel, input int k);
    case (sel)
      SEL_PN15:     return pn_ref(`DAC_PN15_SEED_ONES, k);
      SEL_PN7:      return pn_ref(`DAC_PN7_SEED_ONES, k);
      SEL_PN15_INV: return ~pn_ref(`DAC_PN15_SEED_ONES, k);
      SEL_PN7_INV:  return ~pn_ref(`DAC_PN7_SEED_ONES, k);
      SEL_ZERO:     return 32'h0;
      SEL_PATTERN:  return {pat_s[1], pat_s[0]};
      default:      return {tone_lane(k, 1), tone_lane(k, 0)};
    endcase
  endfunction

  // ******************************
  // Drive tasks
  // ******************************

  // Wait for the next edge and then the drive and sample point
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic host_write(input logic [3:0] addr, input logic [15:0] data);
    check_bit(1'b0, cfg_ack, "cfg_ack low before request");
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_req   = 1'b1;
    tick();
    while (cfg_ack !== 1'b1) tick();
    // Sync pulse sat in the cycle before this ack edge
    if (cfg_op_t'(addr) == OP_SYNC) sync_edge = cyc;
    tick();
    check_bit(1'b1, cfg_ack, "cfg_ack held while cfg_req high");
    // New select was loaded on the ack edge and reaches the outputs one edge later
    if (cfg_op_t'(addr) == OP_SEL) begin
      check_bit(data_sel_t'(data[3:0]) == SEL_DMA, dac_enable,
                "dac_enable one cycle after select");
    end
    // First word of the restarted sources
    if (cfg_op_t'(addr) == OP_SYNC && sel_shadow != SEL_DMA) begin
      check_word(expected_word(sel_shadow, cyc - sync_edge - 1), dac_data,
                 "first word after sync");
    end
    cfg_req = 1'b0;
    tick();
    while (cfg_ack !== 1'b0) tick();
    case (cfg_op_t'(addr))
      OP_SEL:     sel_shadow = data_sel_t'(data[3:0]);
      OP_FORMAT:  fmt_shadow = data[0];
      OP_SCALE_0: scale_s[0] = data;
      OP_INIT_0:  init_s[0] = data;
      OP_INCR_0:  incr_s[0] = data;
      OP_SCALE_1: scale_s[1] = data;
      OP_INIT_1:  init_s[1] = data;
      OP_INCR_1:  incr_s[1] = data;
      OP_PAT_0:   pat_s[0] = data;
      OP_PAT_1:   pat_s[1] = data;
      default: ;
    endcase
    check_sel(sel_shadow, dac_tpl_top_inst.data_sel, "data_sel after write");
    check_bit(sel_shadow == SEL_DMA, dac_enable, "dac_enable after write");
  endtask

  task automatic dma_word(input logic [31:0] word, input logic [31:0] exp);
    dma_data = word;
    tick();
    check_word(exp, dac_data, "DMA word on dac_data");
    check_bit(sel_shadow == SEL_DMA, dac_enable, "dac_enable with DMA word");
  endtask

  task automatic dma_burst(input int n);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      w = $random(seed);
      dma_word(w, w);
    end
  endtask

  // Word index counts edges since the seed or init was loaded
  task automatic check_source(input data_sel_t sel, input int n);
    int k;
    check_sel(sel, dac_tpl_top_inst.data_sel, "data_sel before source check");
    for (int i = 0; i < n; i++) begin
      tick();
      k = cyc - sync_edge - 1;
      check_word(expected_word(sel, k), dac_data, "generated source word");
      check_bit(sel == SEL_DMA, dac_enable, "dac_enable with generated source");
    end
  endtask

  // ******************************
  // Step runner
  // ******************************

  initial begin
    int          n_steps;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] data;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cfg_req    = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    dma_data   = '0;
    sel_shadow = SEL_ZERO;
    fmt_shadow = 1'b0;
    for (int t = 0; t < 2; t++) begin
      scale_s[t] = '0;
      init_s[t]  = '0;
      incr_s[t]  = '0;
      pat_s[t]   = '0;
    end
    $readmemh("dac_tpl_patterns.txt", step_mem);
    n_steps = 0;
    while (n_steps < STEP_MAX && step_mem[4*n_steps] !== 32'hf) n_steps++;
    limit = 40 * n_steps + 200;

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_bit(1'b0, cfg_ack, "cfg_ack after reset");
    check_bit(1'b0, dac_enable, "dac_enable after reset");
    check_word(32'h0, dac_data, "dac_data after reset");
    check_sel(SEL_ZERO, dac_tpl_top_inst.data_sel, "data_sel after reset");

    for (int s = 0; s < n_steps; s++) begin
      op   = step_mem[4*s];
      arg  = step_mem[4*s+1];
      data = step_mem[4*s+2];
      case (op)
        32'h0: host_write(arg[3:0], data[15:0]);
        32'h1: dma_word(data, step_mem[4*s+3]);
        32'h2: check_source(data_sel_t'(arg[3:0]), int'(data));
        32'h3: dma_burst(int'(data));
        default: begin
          $display("pattern step %0d has an unknown operation code %h", s, op);
          abort_run();
        end
      endcase
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dac_tpl_patterns.txt
// op addr/sel data expected, all hex
// op 0 host write, 1 DMA word, 2 check source sel for data cycles, 3 random DMA words, f end
0 0 00000002 00000000 // select DMA
1 0 12345678 12345678
1 0 a5a5f00f a5a5f00f
3 0 000000c8 00000000 // 200 random DMA words
0 8 0000beef 00000000 // pat_0
0 9 0000cafe 00000000 // pat_1
0 f 00001234 00000000 // unmapped address, ignored
0 0 00000001 00000000 // select pattern
2 1 00000004 00000000
0 0 00000003 00000000 // select zero
2 3 00000003 00000000
0 a 00000000 00000000 // sync
0 0 00000007 00000000 // PN15
2 7 00000006 00000000
0 0 00000005 00000000 // PN15 inverted
2 5 00000004 00000000
0 0 00000006 00000000 // PN7
2 6 00000004 00000000
0 0 00000004 00000000 // PN7 inverted
2 4 00000004 00000000
0 2 00008000 00000000 // scale_0
0 3 00000000 00000000 // init_0
0 4 00000400 00000000 // incr_0
0 5 00004000 00000000 // scale_1
0 6 00006000 00000000 // init_1
0 7 00001100 00000000 // incr_1
0 1 00000000 00000000 // offset binary
0 0 00000000 00000000 // select tone
0 a 00000000 00000000 // sync
2 0 00000008 00000000
0 1 00000001 00000000 // two's complement
2 0 00000008 00000000
f 0 00000000 00000000

//--- dac_tpl_top.f
+incdir+.
dac_tpl_pkg.sv
dac_cfg_ctrl.sv
dac_pn_gen.sv
dac_tone_gen.sv
dac_tpl_channel.sv
dac_tpl_top.sv
dac_tpl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DAC transport channel testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f dac_tpl_top.f \
  --top-module dac_tpl_tb \
  -Mdir obj_dir

./obj_dir/Vdac_tpl_tb
